// ==== all.f ====
exec_pkg.sv
regfile_2r1w.sv
regfile_zero.sv
exec_alu.sv
exec_core.sv
tb_clock.sv
tb_exec_core.sv

// ==== exec_alu.sv ====
// ------------------------------------------------------------
// Combinational ALU
// add, sub, and, or, xor, signed set-less-than, shift-left
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_alu import exec_pkg::*; (
        input  wire alu_op_t op,
        input  wire word_t   a,
        input  wire word_t   b,
        output word_t        out
);

        // Signed view of operands for the compare
        logic signed [$bits(word_t)-1:0] a_signed;
        logic signed [$bits(word_t)-1:0] b_signed;

        assign a_signed = $signed(a);
        assign b_signed = $signed(b);

        // ------------------------------------------------------------
        // Operation select
        // ------------------------------------------------------------

        always_comb begin
                unique case (op)
                        OP_ADD: out = a + b;
                        OP_SUB: out = a - b;
                        OP_AND: out = a & b;
                        OP_OR:  out = a | b;
                        OP_XOR: out = a ^ b;
                        // 1 when a below b as two's complement
                        OP_SLT: out = (a_signed < b_signed) ? word_t'(1) : word_t'(0);
                        // Only the low 5 bits count as shift amount
                        OP_SLL: out = a << b[4:0];
                        default: out = '0;
                endcase
        end

        // ------------------------------------------------------------
        // Assertions
        // ------------------------------------------------------------

        // Whoever drives op should only issue defined codes
        always_comb begin
                if (!$isunknown(op)) begin
                        a_op_defined: assert (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                                         OP_XOR, OP_SLT, OP_SLL})
                        else $error("exec_alu: undefined op code %0d", op);
                end
        end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
// ------------------------------------------------------------
// Execute core top level
// Register file read, ALU, write-back and output register
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_core import exec_pkg::*; #(
        parameter int p_num_regs = 32
) (
        input  wire logic      clk,
        input  wire logic      reset,

        // Issue side carries one operation per strobe
        input  wire logic      issue_en,
        input  wire alu_op_t   issue_op,
        input  wire reg_addr_t issue_rd,
        input  wire reg_addr_t issue_rs1,
        input  wire reg_addr_t issue_rs2,

        // Result side is valid for exactly one cycle
        output logic           result_valid,
        output word_t          result,
        output logic           result_zero
);

        // Register count must fit the address type
        if ((p_num_regs < 2) || (p_num_regs > MAX_REGS)) begin : g_bad_num_regs
                $error("exec_core: p_num_regs %0d out of range", p_num_regs);
        end

        // Operands from the register file
        word_t rs1_data;
        word_t rs2_data;

        // ALU output, also the write-back value
        word_t alu_out;

        // ------------------------------------------------------------
        // Datapath
        // ------------------------------------------------------------

        // Reads are combinational so operands arrive the same cycle
        regfile_zero #(
                .p_num_regs (p_num_regs)
        ) u_regfile_zero (
                .clk      (clk),
                .reset    (reset),
                .rd_addr0 (issue_rs1),
                .rd_data0 (rs1_data),
                .rd_addr1 (issue_rs2),
                .rd_data1 (rs2_data),
                .wr_en    (issue_en),
                .wr_addr  (issue_rd),
                .wr_data  (alu_out)
        );

        exec_alu u_exec_alu (
                .op  (issue_op),
                .a   (rs1_data),
                .b   (rs2_data),
                .out (alu_out)
        );

        // ------------------------------------------------------------
        // Output register
        // ------------------------------------------------------------

        // Loaded on the same edge that writes the register file
        always_ff @(posedge clk) begin
                if (reset) begin
                        result_valid <= 1'b0;
                        result       <= '0;
                        result_zero  <= 1'b0;
                end else begin
                        result_valid <= issue_en;
                        if (issue_en) begin
                                result      <= alu_out;
                                result_zero <= (alu_out == '0);
                        end
                end
        end

        // Issued fields must be known and sources must have been written
        a_issue_known: assert property (@(posedge clk) disable iff (reset)
                issue_en |-> !$isunknown({issue_op, issue_rd, issue_rs1, issue_rs2, alu_out}));

endmodule

`default_nettype wire

// ==== exec_patterns.txt ====
# gap op rd rs1 rs2 result zero   (gap = idle cycles before issue, decimal; op, result in hex)
# op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sll; r1 holds 1 before the first issue
2 1 2 0 1 ffffffff 0
0 0 3 1 1 00000002 0
0 0 4 3 3 00000004 0
0 0 5 4 4 00000008 0
0 0 6 5 5 00000010 0
0 6 7 1 6 00010000 0
0 3 8 7 5 00010008 0
0 6 9 2 6 ffff0000 0
0 3 10 9 4 ffff0004 0
0 6 11 8 4 00100080 0
0 3 12 11 3 00100082 0
1 0 13 12 8 0011008a 0
0 1 14 8 12 fff0ff86 0
0 2 15 7 5 00000000 1
0 2 16 10 12 00100000 0
0 3 17 9 12 ffff0082 0
0 4 18 10 2 0000fffb 0
0 4 19 8 8 00000000 1
0 1 20 12 12 00000000 1
# signed compares
0 5 21 2 1 00000001 0
0 5 22 1 2 00000000 1
0 5 23 9 2 00000001 0
0 5 24 2 9 00000000 1
0 5 25 10 9 00000000 1
0 5 26 14 13 00000001 0
0 5 27 3 3 00000000 1
0 6 28 12 3 00400208 0
0 0 30 6 5 00000018 0
0 3 30 30 4 0000001c 0
0 3 30 30 3 0000001e 0
0 3 30 30 1 0000001f 0
0 6 31 1 30 80000000 0
0 5 29 31 1 00000001 0
0 6 28 31 1 00000000 1
0 6 27 1 8 00000100 0
0 0 26 6 6 00000020 0
0 6 25 12 26 00100082 0
0 0 0 2 2 fffffffe 0
0 0 24 0 0 00000000 1
0 3 23 0 12 00100082 0
0 1 22 12 0 00100082 0
0 0 20 3 3 00000004 0
0 0 20 20 20 00000008 0
3 0 19 20 0 00000008 0
5 3 18 20 1 00000009 0
0 4 17 2 20 fffffff7 0
0 0 17 17 1 fffffff8 0
0 1 17 17 2 fffffff9 0
0 2 17 17 30 00000019 0
2 5 16 17 30 00000001 0
0 0 15 2 1 00000000 1
0 1 14 0 31 80000000 0
1 2 13 2 2 ffffffff 0
0 6 12 13 30 80000000 0
0 0 11 31 31 00000000 1
0 5 10 14 31 00000000 1
0 4 9 31 2 7fffffff 0
0 5 8 9 31 00000000 1
0 5 7 31 9 00000001 0
4 3 6 0 0 00000000 1

// ==== exec_pkg.sv ====
// ------------------------------------------------------------
// Shared types and constants for the execute core
// Word and register address types, ALU operation codes
// ------------------------------------------------------------

`default_nettype none

package exec_pkg;

        // ------------------------------------------------------------
        // Data and address types
        // ------------------------------------------------------------

        // One machine word as held in the register file
        typedef logic [31:0] word_t;

        // Register number, wide enough for a full RISC integer file
        typedef logic [4:0] reg_addr_t;

        // ALU operation selector
        typedef logic [2:0] alu_op_t;

        // Largest register count that reg_addr_t can name
        localparam int MAX_REGS = 32;

        // ------------------------------------------------------------
        // ALU operation codes
        // ------------------------------------------------------------

        localparam alu_op_t OP_ADD = 3'd0;
        localparam alu_op_t OP_SUB = 3'd1;
        localparam alu_op_t OP_AND = 3'd2;
        localparam alu_op_t OP_OR  = 3'd3;
        localparam alu_op_t OP_XOR = 3'd4;
        // Signed compare, result is 1 or 0
        localparam alu_op_t OP_SLT = 3'd5;
        // Shift amount from low 5 bits of operand b
        localparam alu_op_t OP_SLL = 3'd6;

endpackage

`default_nettype wire

// ==== regfile_2r1w.sv ====
// ------------------------------------------------------------
// Generic register file, two combinational reads, one write
// Write on rising edge, address checks as assertions
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module regfile_2r1w import exec_pkg::*; #(
        parameter int p_data_nbits  = 32,
        parameter int p_num_entries = 32
) (
        input  wire logic                    clk,
        input  wire logic                    reset,

        // Read port 0
        input  wire reg_addr_t               read_addr0,
        output logic      [p_data_nbits-1:0] read_data0,

        // Read port 1
        input  wire reg_addr_t               read_addr1,
        output logic      [p_data_nbits-1:0] read_data1,

        // Write port, sampled on the rising edge
        input  wire logic                    write_en,
        input  wire reg_addr_t               write_addr,
        input  wire logic [p_data_nbits-1:0] write_data
);

        // Storage array, contents undefined until written
        logic [p_data_nbits-1:0] rfile [p_num_entries];

        // Both reads are purely combinational
        assign read_data0 = rfile[read_addr0];
        assign read_data1 = rfile[read_addr1];

        always_ff @(posedge clk) begin
                if (write_en) begin
                        rfile[write_addr] <= write_data;
                end
        end

        // ------------------------------------------------------------
        // Assertions
        // ------------------------------------------------------------

        // Enable must always be a clean 0 or 1 once out of reset
        a_write_en_known: assert property (@(posedge clk) disable iff (reset)
                !$isunknown(write_en));

        // Write address must be known and name an existing entry
        a_write_addr_ok: assert property (@(posedge clk) disable iff (reset)
                write_en |-> (!$isunknown(write_addr) && (int'(write_addr) < p_num_entries)));

endmodule

`default_nettype wire

// ==== regfile_zero.sv ====
// ------------------------------------------------------------
// Integer register file with r0 hardwired to zero
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module regfile_zero import exec_pkg::*; #(
        parameter int p_num_regs = 32
) (
        input  wire logic      clk,
        input  wire logic      reset,
        input  wire reg_addr_t rd_addr0,
        output word_t          rd_data0,
        input  wire reg_addr_t rd_addr1,
        output word_t          rd_data1,
        input  wire logic      wr_en,
        input  wire reg_addr_t wr_addr,
        input  wire word_t     wr_data
);

        // Raw data straight from the storage array
        word_t rf_data0;
        word_t rf_data1;

        regfile_2r1w #(
                .p_data_nbits  ($bits(word_t)),
                .p_num_entries (p_num_regs)
        ) u_regfile_2r1w (
                .clk        (clk),
                .reset      (reset),
                .read_addr0 (rd_addr0),
                .read_data0 (rf_data0),
                .read_addr1 (rd_addr1),
                .read_data1 (rf_data1),
                .write_en   (wr_en),
                .write_addr (wr_addr),
                .write_data (wr_data)
        );

        // r0 reads as zero even if something was written there
        assign rd_data0 = (rd_addr0 == '0) ? '0 : rf_data0;
        assign rd_data1 = (rd_addr1 == '0) ? '0 : rf_data1;

        // Known read addresses must fall inside the configured file
        a_rd_addr_range: assert property (@(posedge clk) disable iff (reset)
                (!$isunknown({rd_addr0, rd_addr1})) |->
                ((int'(rd_addr0) < p_num_regs) && (int'(rd_addr1) < p_num_regs)));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        -f all.f \
        --top-module tb_exec_core \
        -o sim_exec_core

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_exec_core

// ==== tb_clock.sv ====
// ------------------------------------------------------------
// Testbench clock source, free running from time zero
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
        parameter int p_half_period_ns = 4
) (
        output logic clk
);

        // Low for the first half period, 8 ns period by default
        initial begin
                clk = 1'b0;
                forever #(p_half_period_ns) clk = ~clk;
        end

endmodule

`default_nettype wire

// ==== tb_exec_core.sv ====
// ------------------------------------------------------------
// Testbench for the execute core
// Reads instruction patterns, drives issues, checks results
// Watchdog limits the run to the pattern length
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_exec_core import exec_pkg::*;;

        localparam int MAX_PATTERNS = 128;

        // DUT connections
        logic      clk;
        logic      reset;
        logic      issue_en;
        alu_op_t   issue_op;
        reg_addr_t issue_rd;
        reg_addr_t issue_rs1;
        reg_addr_t issue_rs2;
        logic      result_valid;
        word_t     result;
        logic      result_zero;

        // Pattern table as read from the data file
        int        pat_gap    [MAX_PATTERNS];
        alu_op_t   pat_op     [MAX_PATTERNS];
        reg_addr_t pat_rd     [MAX_PATTERNS];
        reg_addr_t pat_rs1    [MAX_PATTERNS];
        reg_addr_t pat_rs2    [MAX_PATTERNS];
        word_t     pat_result [MAX_PATTERNS];
        logic      pat_zero   [MAX_PATTERNS];
        int        num_patterns = 0;
        int        watchdog_cycles = 0;
        logic      patterns_loaded = 1'b0;

        // Outstanding results with one entry per issue and oldest first
        string     exp_name_q   [$];
        word_t     exp_result_q [$];
        logic      exp_zero_q   [$];
        int        exp_cycle_q  [$];

        // Rising edges seen so far
        int        cycle_count = 0;

        tb_clock u_tb_clock (
                .clk (clk)
        );

        exec_core #(
                .p_num_regs (32)
        ) u_exec_core (
                .clk          (clk),
                .reset        (reset),
                .issue_en     (issue_en),
                .issue_op     (issue_op),
                .issue_rd     (issue_rd),
                .issue_rs1    (issue_rs1),
                .issue_rs2    (issue_rs2),
                .result_valid (result_valid),
                .result       (result),
                .result_zero  (result_zero)
        );

        // ------------------------------------------------------------
        // Helpers
        // ------------------------------------------------------------

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic check_word(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        $display("FAILED %s result: expected %h, actual %h", name, expected, actual);
                        fail_run("result word mismatch");
                end
        endtask

        task automatic check_flag(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("FAILED %s zero flag: expected %b, actual %b", name, expected, actual);
                        fail_run("zero flag mismatch");
                end
        endtask

        function automatic string op_name(input alu_op_t op);
                case (op)
                        OP_ADD:  return "add";
                        OP_SUB:  return "sub";
                        OP_AND:  return "and";
                        OP_OR:   return "or";
                        OP_XOR:  return "xor";
                        OP_SLT:  return "slt";
                        OP_SLL:  return "sll";
                        default: return "undefined";
                endcase
        endfunction

        // Lines starting with # are comments and data lines hold 7 columns
        task automatic load_patterns();
                int    fd;
                int    gap_sum;
                int    fields [7];
                string line;
                gap_sum = 0;
                fd = $fopen("exec_patterns.txt", "r");
                if (fd == 0) begin
                        fail_run("could not open exec_patterns.txt");
                end
                while (!$feof(fd)) begin
                        line = "";
                        void'($fgets(line, fd));
                        if ((line.len() > 1) && (line.getc(0) != "#")) begin
                                if ($sscanf(line, "%d %h %d %d %d %h %d", fields[0], fields[1],
                                            fields[2], fields[3], fields[4], fields[5],
                                            fields[6]) != 7) begin
                                        fail_run("malformed line in exec_patterns.txt");
                                end
                                if (num_patterns >= MAX_PATTERNS) begin
                                        fail_run("too many lines in exec_patterns.txt");
                                end
                                pat_gap[num_patterns]    = fields[0];
                                pat_op[num_patterns]     = alu_op_t'(fields[1]);
                                pat_rd[num_patterns]     = reg_addr_t'(fields[2]);
                                pat_rs1[num_patterns]    = reg_addr_t'(fields[3]);
                                pat_rs2[num_patterns]    = reg_addr_t'(fields[4]);
                                pat_result[num_patterns] = word_t'(fields[5]);
                                pat_zero[num_patterns]   = (fields[6] != 0);
                                gap_sum += fields[0];
                                num_patterns++;
                        end
                end
                $fclose(fd);
                watchdog_cycles = num_patterns + gap_sum + 20;
                patterns_loaded = 1'b1;
        endtask

        // Called 1 ns after an edge and returns 1 ns after the issuing edge
        task automatic issue_pattern(input int idx);
                // Idle cycles hold the old fields, so a leaked write would show
                for (int g = 0; g < pat_gap[idx]; g++) begin
                        issue_en = 1'b0;
                        @(posedge clk);
                        #1;
                end
                issue_en  = 1'b1;
                issue_op  = pat_op[idx];
                issue_rd  = pat_rd[idx];
                issue_rs1 = pat_rs1[idx];
                issue_rs2 = pat_rs2[idx];
                exp_name_q.push_back($sformatf("pattern %0d %s", idx + 1, op_name(pat_op[idx])));
                exp_result_q.push_back(pat_result[idx]);
                exp_zero_q.push_back(pat_zero[idx]);
                // Sampled at the next edge with the result due right after it
                exp_cycle_q.push_back(cycle_count + 1);
                @(posedge clk);
                #1;
        endtask

        // ------------------------------------------------------------
        // Processes
        // ------------------------------------------------------------

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
        end

        // Outputs are sampled mid-cycle where they are settled
        always @(negedge clk) begin
                if (!reset) begin
                        if (result_valid === 1'b1) begin
                                if (exp_cycle_q.size() == 0) begin
                                        fail_run("result_valid pulsed with no instruction issued");
                                end else if (exp_cycle_q[0] != cycle_count) begin
                                        fail_run("result_valid came in the wrong cycle");
                                end else begin
                                        check_word(exp_name_q[0], exp_result_q[0], result);
                                        check_flag(exp_name_q[0], exp_zero_q[0], result_zero);
                                        void'(exp_name_q.pop_front());
                                        void'(exp_result_q.pop_front());
                                        void'(exp_zero_q.pop_front());
                                        void'(exp_cycle_q.pop_front());
                                end
                        end else if (result_valid !== 1'b0) begin
                                fail_run("result_valid is unknown");
                        end else if ((exp_cycle_q.size() > 0) && (exp_cycle_q[0] < cycle_count)) begin
                                fail_run("result_valid missing one cycle after an issue");
                        end
                end
        end

        initial begin
                wait (patterns_loaded);
                repeat (watchdog_cycles) @(posedge clk);
                fail_run("watchdog expired before all patterns finished");
        end

        initial begin
                reset     = 1'b1;
                issue_en  = 1'b0;
                issue_op  = OP_ADD;
                issue_rd  = '0;
                issue_rs1 = '0;
                issue_rs2 = '0;
                load_patterns();
                if (num_patterns == 0) begin
                        fail_run("no patterns found in exec_patterns.txt");
                end
                // Only zero can be built from r0, so r1 starts out holding 1
                u_exec_core.u_regfile_zero.u_regfile_2r1w.rfile[1] <= word_t'(1);
                repeat (5) @(posedge clk);
                #1;
                reset = 1'b0;
                // Output register comes out of reset cleared
                check_word("after reset", '0, result);
                check_flag("after reset", 1'b0, result_zero);
                for (int i = 0; i < num_patterns; i++) begin
                        issue_pattern(i);
                end
                issue_en = 1'b0;
                repeat (3) @(posedge clk);
                if (exp_cycle_q.size() == 0) begin
                        $display("TEST PASSED");
                        $finish;
                end else begin
                        fail_run("results still outstanding at end of run");
                end
        end

endmodule

`default_nettype wire
